//--- hdl/sgb_load_pkg.sv
// Loader definitions for the Super Game Boy system block
// Host download beat, download index values, cheat code layout
// and the work RAM fill port with its stripe pattern

package sgb_load_pkg;

	// ====================
	// Host download channel
	// ====================
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] dout;
		logic        wr;
	} ioctl_bus_t;

	// Only the low six bits take part in the compare
	localparam logic [7:0] IDX_GB_CART  = 8'h01;
	localparam logic [7:0] IDX_MSU_DATA = 8'h03;
	localparam logic [7:0] IDX_CART     = 8'h04;
	localparam logic [7:0] IDX_BOOT     = 8'h05;
	// Cheat list uses the full index
	localparam logic [7:0] IDX_CHEAT    = 8'hFF;

	// ====================
	// Cheat code
	// ====================
	// Each field arrives low word first
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// ====================
	// Work RAM fill
	// ====================
	localparam int RAM_ADDR_W = 17;

	typedef struct packed {
		logic                  en;
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} fill_port_t;

	// Stripe bytes, A where addr[8] ^ addr[2] is set
	localparam logic [7:0] FILL_BYTE_A = 8'h66;
	localparam logic [7:0] FILL_BYTE_B = 8'h99;

endpackage

//--- hdl/sgb_audio_pkg.sv
// Audio definitions for the Super Game Boy system block
// Signed sample and stereo pair types, plus the Game Boy
// sample scaling used by the mixer

package sgb_audio_pkg;

	// Signed 16-bit PCM sample
	typedef logic signed [15:0] sample_t;

	// Left and right pair
	typedef struct packed {
		sample_t l;
		sample_t r;
	} stereo_t;

	// Game Boy sample keeps its sign bit and bits 12..0,
	// then moves up by this many bits
	localparam int GB_SHIFT = 2;

	// Low bits of the Game Boy sample that are kept
	localparam int GB_KEEP_MSB = 12;

endpackage

//--- hdl/download_router.sv
// Download router
// Decodes the host download index into load strobes and builds
// the core reset from every reset source. The core reset is only
// updated once every four clocks.

module download_router
	import sgb_load_pkg::*;
(
	input  logic       clk_sys,
	input  logic       RESET,
	input  ioctl_bus_t ioctl,
	input  logic       osd_reset,
	input  logic       clearing,
	output logic       cart_loading,
	output logic       gb_cart_loading,
	output logic       boot_loading,
	output logic       cheat_loading,
	output logic       core_reset
);

	logic [5:0] idx_low;
	logic       msu_data_loading;
	logic       reset_req;
	logic [1:0] div;

	// ====================
	// Index decode
	// ====================
	assign idx_low = ioctl.index[5:0];

	assign cart_loading     = ioctl.download & (idx_low == IDX_CART[5:0]);
	assign boot_loading     = ioctl.download & (idx_low == IDX_BOOT[5:0]);
	assign msu_data_loading = ioctl.download & (idx_low == IDX_MSU_DATA[5:0]);
	// Index 0 is also a Game Boy cartridge
	assign gb_cart_loading  = ioctl.download &
		((idx_low == IDX_GB_CART[5:0]) || (ioctl.index == 8'h00));
	assign cheat_loading    = ioctl.download & (ioctl.index == IDX_CHEAT);

	// ====================
	// Core reset
	// ====================
	assign reset_req = RESET | osd_reset | cart_loading | gb_cart_loading |
		boot_loading | msu_data_loading | clearing;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			div        <= 2'd0;
			core_reset <= 1'b1;
		end else begin
			div <= div + 2'd1;
			// Sample the request on one phase of the divider
			if (div == 2'd2)
				core_reset <= reset_req;
		end
	end

endmodule

//--- hdl/cheat_code_assembler.sv
// Cheat code assembler
// Collects eight 16-bit download words into one cheat code and
// pulses valid for one clock once the last word is in. Also flags
// the start of a new cheat list or Game Boy cartridge.

module cheat_code_assembler
	import sgb_load_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_bus_t  ioctl,
	input  logic        cheat_loading,
	input  logic        gb_cart_loading,
	output cheat_code_t cheat_code,
	output logic        cheat_valid,
	output logic        cheat_reset
);

	logic cheat_wr;

	assign cheat_wr = cheat_loading & ioctl.wr;

	// New list starts at address 0
	assign cheat_reset = (cheat_wr && (ioctl.addr == '0)) || gb_cart_loading;

	// Code words, payload only
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (ioctl.addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= ioctl.dout;
				4'd2:  cheat_code.flags[31:16]   <= ioctl.dout;
				4'd4:  cheat_code.address[15:0]  <= ioctl.dout;
				4'd6:  cheat_code.address[31:16] <= ioctl.dout;
				4'd8:  cheat_code.compare[15:0]  <= ioctl.dout;
				4'd10: cheat_code.compare[31:16] <= ioctl.dout;
				4'd12: cheat_code.replace[15:0]  <= ioctl.dout;
				4'd14: cheat_code.replace[31:16] <= ioctl.dout;
				default: ;
			endcase
		end
	end

	// One clock strobe after the top replace word
	always_ff @(posedge clk_sys) begin
		if (RESET)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= cheat_wr && (ioctl.addr[3:0] == 4'd14);
	end

endmodule

//--- hdl/ram_clear_sequencer.sv
// Work RAM clear sequencer
// On the start of a cartridge load, sweeps every RAM address once
// and writes the striped fill pattern through the second port

module ram_clear_sequencer
	import sgb_load_pkg::*;
#(
	parameter int FILL_ADDR_W = 17
) (
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       cart_loading,
	output logic       clearing,
	output fill_port_t fill
);

	logic                   cart_q;
	logic                   cart_q_d;
	logic [FILL_ADDR_W-1:0] fill_cnt;

	// ====================
	// Load edge and sweep
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_q   <= 1'b0;
			cart_q_d <= 1'b0;
			clearing <= 1'b0;
			fill_cnt <= '0;
		end else begin
			cart_q   <= cart_loading;
			cart_q_d <= cart_q;

			if (cart_q & ~cart_q_d)
				clearing <= 1'b1;
			// Last address goes out this cycle
			if (&fill_cnt)
				clearing <= 1'b0;

			if (clearing)
				fill_cnt <= fill_cnt + 1'b1;
			else
				fill_cnt <= '0;
		end
	end

	// ====================
	// Fill port
	// ====================
	assign fill.en   = clearing;
	assign fill.addr = RAM_ADDR_W'(fill_cnt);
	assign fill.data = (fill_cnt[8] ^ fill_cnt[2]) ? FILL_BYTE_A : FILL_BYTE_B;

endmodule

//--- hdl/audio_mixer.sv
// Audio mixer
// Adds the scaled Game Boy audio to the main audio and, when the
// MSU player is on, mixes its samples in as well. Output is registered.

module audio_mixer
	import sgb_audio_pkg::*;
(
	input  logic    clk_sys,
	input  logic    RESET,
	input  stereo_t main_audio,
	input  stereo_t gb_audio,
	input  stereo_t msu_audio,
	input  logic    msu_enable,
	output stereo_t audio_out
);

	stereo_t mix;

	// Each stage sums in 17 bits and keeps the top 16
	function automatic sample_t mix_channel(input sample_t main_s, input sample_t gb_s,
			input sample_t msu_s, input logic msu_on);
		logic [15:0] gb_scaled;
		logic [16:0] base_sum;
		logic [16:0] msu_sum;
		gb_scaled = {gb_s[15], gb_s[GB_KEEP_MSB:0], {GB_SHIFT{1'b0}}};
		base_sum  = {main_s[15], main_s} + {gb_scaled[15], gb_scaled};
		msu_sum   = {base_sum[16], base_sum[16:1]} + {msu_s[15], msu_s};
		if (msu_on)
			return msu_sum[16:1];
		return base_sum[16:1];
	endfunction

	always_comb begin
		mix.l = mix_channel(main_audio.l, gb_audio.l, msu_audio.l, msu_enable);
		mix.r = mix_channel(main_audio.r, gb_audio.r, msu_audio.r, msu_enable);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET)
			audio_out <= '0;
		else
			audio_out <= mix;
	end

endmodule

//--- hdl/sgb_system_top.sv
// Super Game Boy system support top level
// Ties the download router, cheat assembler, RAM clear sequencer
// and audio mixer around the core

module sgb_system_top
	import sgb_load_pkg::*;
	import sgb_audio_pkg::*;
#(
	parameter int FILL_ADDR_W = 17
) (
	input  logic        clk_sys,
	input  logic        RESET,
	input  ioctl_bus_t  ioctl,
	input  logic        osd_reset,
	input  stereo_t     main_audio,
	input  stereo_t     gb_audio,
	input  stereo_t     msu_audio,
	input  logic        msu_enable,
	output logic        cart_loading,
	output logic        gb_cart_loading,
	output logic        boot_loading,
	output logic        core_reset,
	output cheat_code_t cheat_code,
	output logic        cheat_valid,
	output logic        cheat_reset,
	output logic        clearing,
	output fill_port_t  fill,
	output stereo_t     audio_out
);

	logic cheat_loading;

	// ====================
	// Loader side
	// ====================
	download_router u_router (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.ioctl           (ioctl),
		.osd_reset       (osd_reset),
		.clearing        (clearing),
		.cart_loading    (cart_loading),
		.gb_cart_loading (gb_cart_loading),
		.boot_loading    (boot_loading),
		.cheat_loading   (cheat_loading),
		.core_reset      (core_reset)
	);

	cheat_code_assembler u_cheats (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.ioctl           (ioctl),
		.cheat_loading   (cheat_loading),
		.gb_cart_loading (gb_cart_loading),
		.cheat_code      (cheat_code),
		.cheat_valid     (cheat_valid),
		.cheat_reset     (cheat_reset)
	);

	ram_clear_sequencer #(
		.FILL_ADDR_W (FILL_ADDR_W)
	) u_clear (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_loading (cart_loading),
		.clearing     (clearing),
		.fill         (fill)
	);

	// ====================
	// Audio
	// ====================
	audio_mixer u_mixer (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.main_audio (main_audio),
		.gb_audio   (gb_audio),
		.msu_audio  (msu_audio),
		.msu_enable (msu_enable),
		.audio_out  (audio_out)
	);

endmodule

//--- verification/sgb_tb_asserts.sv
// Bound checks on the Super Game Boy system top level
// Cheat valid pulse width, fill address order and the start of each sweep

module sgb_tb_asserts
	import sgb_load_pkg::*;
(
	input logic       clk_sys,
	input logic       RESET,
	input logic       cheat_valid,
	input logic       clearing,
	input fill_port_t fill
);
	timeunit 1ns;
	timeprecision 1ps;

	// Read by the testbench at the end of the run
	int assert_errors = 0;

	a_valid_single: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_valid |=> !cheat_valid)
		else begin
			assert_errors++;
			$error("cheat_valid stayed high for two cycles");
		end

	// Sweep moves up one address per clock
	a_fill_order: assert property (@(posedge clk_sys) disable iff (RESET)
		(fill.en && $past(fill.en)) |-> (fill.addr == $past(fill.addr) + RAM_ADDR_W'(1)))
		else begin
			assert_errors++;
			$error("fill address did not step by one");
		end

	// A clear begins with a write to the bottom of the RAM
	a_fill_start: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(clearing) |-> (fill.en && (fill.addr == '0)))
		else begin
			assert_errors++;
			$error("clear did not start with a fill write at address 0");
		end

endmodule

bind sgb_system_top sgb_tb_asserts u_asserts (
	.clk_sys     (clk_sys),
	.RESET       (RESET),
	.cheat_valid (cheat_valid),
	.clearing    (clearing),
	.fill        (fill)
);

//--- verification/sgb_tb.sv
// Testbench for the Super Game Boy system top level
// Directed tests for load decode, cheat assembly, RAM clear,
// core reset and the audio mix

module sgb_tb
	import sgb_load_pkg::*;
	import sgb_audio_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CYCLES = 5000;

	logic        clk_sys = 1'b0;
	logic        RESET;
	ioctl_bus_t  ioctl;
	logic        osd_reset;
	stereo_t     main_audio;
	stereo_t     gb_audio;
	stereo_t     msu_audio;
	logic        msu_enable;
	logic        cart_loading;
	logic        gb_cart_loading;
	logic        boot_loading;
	logic        core_reset;
	cheat_code_t cheat_code;
	logic        cheat_valid;
	logic        cheat_reset;
	logic        clearing;
	fill_port_t  fill;
	stereo_t     audio_out;

	int checks = 0;
	int errors = 0;
	int cycle_count = 0;

	sgb_system_top #(.FILL_ADDR_W(10)) dut (.*);

	always #5 clk_sys = ~clk_sys;

	// Hung run guard
	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ====================
	// Compare tasks
	// ====================
	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_code(input string name, input cheat_code_t exp, input cheat_code_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_fill(input string name, input fill_port_t exp, input fill_port_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected en %b addr %h data %h, actual en %b addr %h data %h",
				name, exp.en, exp.addr, exp.data, act.en, act.addr, act.data);
		end
	endtask

	task automatic check_stereo(input string name, input stereo_t exp, input stereo_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %0d/%0d, actual %0d/%0d",
				name, exp.l, exp.r, act.l, act.r);
		end
	endtask

	// Waits up to 4 falling edges for core_reset to reach a level
	task automatic expect_core_reset(input string name, input logic level);
		int n;
		n = 0;
		while (core_reset !== level && n < 4) begin
			@(negedge clk_sys);
			n++;
		end
		checks++;
		if (core_reset !== level) begin
			errors++;
			$display("%s: core_reset did not go to %b within 4 cycles", name, level);
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while ((clearing || core_reset) && n < 1200) begin
			@(negedge clk_sys);
			n++;
		end
		if (clearing || core_reset) begin
			errors++;
			$display("Design stayed busy for 1200 cycles after the load tests");
		end
	endtask

	// Reference mix, one channel
	function automatic sample_t mix_model(input sample_t main_s, input sample_t gb_s,
			input sample_t msu_s, input logic msu_on);
		logic signed [13:0] gb_kept;
		int acc;
		gb_kept = {gb_s[15], gb_s[12:0]};
		acc = (int'(main_s) + int'(gb_kept) * (1 << GB_SHIFT)) >>> 1;
		if (msu_on)
			acc = (acc + int'(msu_s)) >>> 1;
		return sample_t'(acc);
	endfunction

	// ====================
	// Directed tests
	// ====================
	task automatic test_load_strobes();
		logic [7:0] idx_list [7];
		logic [5:0] low;
		idx_list = '{8'h04, 8'h01, 8'h00, 8'h05, 8'h03, 8'hFF, 8'h02};
		foreach (idx_list[i]) begin
			@(negedge clk_sys);
			ioctl.download = 1'b1;
			ioctl.index = idx_list[i];
			@(posedge clk_sys);
			low = idx_list[i][5:0];
			check_bit($sformatf("strobes %h cart", idx_list[i]), low == 6'd4, cart_loading);
			check_bit($sformatf("strobes %h gb cart", idx_list[i]),
				low == 6'd1 || idx_list[i] == 8'h00, gb_cart_loading);
			check_bit($sformatf("strobes %h boot", idx_list[i]), low == 6'd5, boot_loading);
			@(negedge clk_sys);
			ioctl.download = 1'b0;
			@(posedge clk_sys);
			check_bit("strobes idle cart", 1'b0, cart_loading);
			check_bit("strobes idle gb cart", 1'b0, gb_cart_loading);
			check_bit("strobes idle boot", 1'b0, boot_loading);
		end
		// Index 4 kicked off a clear
		wait_idle();
	endtask

	task automatic test_cheat_code();
		logic [15:0] words [8];
		cheat_code_t exp;
		int i;
		for (i = 0; i < 8; i++)
			words[i] = 16'($urandom);
		exp.flags   = {words[1], words[0]};
		exp.address = {words[3], words[2]};
		exp.compare = {words[5], words[4]};
		exp.replace = {words[7], words[6]};
		for (i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			if (i > 0)
				check_bit("cheat valid early", 1'b0, cheat_valid);
			ioctl.download = 1'b1;
			ioctl.index = IDX_CHEAT;
			ioctl.addr = 25'(2 * i);
			ioctl.dout = words[i];
			ioctl.wr = 1'b1;
			@(posedge clk_sys);
			check_bit($sformatf("cheat reset at %0d", 2 * i), i == 0, cheat_reset);
		end
		@(negedge clk_sys);
		check_bit("cheat valid", 1'b1, cheat_valid);
		check_code("cheat code", exp, cheat_code);
		ioctl.wr = 1'b0;
		ioctl.download = 1'b0;
		@(negedge clk_sys);
		check_bit("cheat valid end", 1'b0, cheat_valid);
		check_code("cheat code held", exp, cheat_code);
	endtask

	task automatic test_ram_clear();
		fill_port_t exp;
		int n;
		int wait_cycles;
		@(negedge clk_sys);
		ioctl.download = 1'b1;
		ioctl.index = IDX_CART;
		expect_core_reset("cart load start", 1'b1);
		n = 0;
		wait_cycles = 0;
		while (n < 1024 && wait_cycles < 1100) begin
			@(negedge clk_sys);
			wait_cycles++;
			if (fill.en) begin
				exp.en = 1'b1;
				exp.addr = RAM_ADDR_W'(n);
				// Stripe changes every 4 bytes and flips every 256
				exp.data = (((n >> 8) & 1) != ((n >> 2) & 1)) ? FILL_BYTE_A : FILL_BYTE_B;
				check_fill($sformatf("fill write %0d", n), exp, fill);
				check_bit("core reset during clear", 1'b1, core_reset);
				n++;
			end
			// Load ends while the clear keeps running
			if (n == 16)
				ioctl.download = 1'b0;
		end
		if (n < 1024) begin
			errors++;
			$display("RAM clear stopped after %0d of 1024 writes", n);
		end
		@(negedge clk_sys);
		check_bit("clearing after last write", 1'b0, clearing);
		check_bit("fill en after last write", 1'b0, fill.en);
		expect_core_reset("clear end", 1'b0);
	endtask

	task automatic test_core_reset();
		@(negedge clk_sys);
		ioctl.download = 1'b1;
		ioctl.index = IDX_BOOT;
		expect_core_reset("boot load start", 1'b1);
		repeat (6) @(negedge clk_sys);
		check_bit("boot load hold", 1'b1, core_reset);
		ioctl.download = 1'b0;
		expect_core_reset("boot load end", 1'b0);
		@(negedge clk_sys);
		osd_reset = 1'b1;
		expect_core_reset("menu reset start", 1'b1);
		repeat (6) @(negedge clk_sys);
		check_bit("menu reset hold", 1'b1, core_reset);
		osd_reset = 1'b0;
		expect_core_reset("menu reset end", 1'b0);
	endtask

	task automatic test_audio_mix();
		stereo_t exp;
		int i;
		for (i = 0; i <= 50; i++) begin
			@(negedge clk_sys);
			if (i > 0)
				check_stereo($sformatf("audio set %0d", i - 1), exp, audio_out);
			main_audio = stereo_t'($urandom);
			gb_audio = stereo_t'($urandom);
			msu_audio = stereo_t'($urandom);
			msu_enable = i[0];
			exp.l = mix_model(main_audio.l, gb_audio.l, msu_audio.l, msu_enable);
			exp.r = mix_model(main_audio.r, gb_audio.r, msu_audio.r, msu_enable);
		end
	endtask

	// ====================
	// Run
	// ====================
	initial begin
		void'($urandom(32'ha051_5e8f));
		RESET = 1'b1;
		ioctl = '0;
		osd_reset = 1'b0;
		main_audio = '0;
		gb_audio = '0;
		msu_audio = '0;
		msu_enable = 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
		check_bit("reset cheat valid", 1'b0, cheat_valid);
		check_bit("reset clearing", 1'b0, clearing);
		check_bit("reset fill en", 1'b0, fill.en);

		test_load_strobes();
		test_cheat_code();
		test_ram_clear();
		test_core_reset();
		test_audio_mix();

		$display("Checks: %0d, compare errors: %0d, assertion errors: %0d",
			checks, errors, dut.u_asserts.assert_errors);
		if (errors == 0 && dut.u_asserts.assert_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verilog.f
hdl/sgb_load_pkg.sv
hdl/sgb_audio_pkg.sv
hdl/download_router.sv
hdl/cheat_code_assembler.sv
hdl/ram_clear_sequencer.sv
hdl/audio_mixer.sv
hdl/sgb_system_top.sv
verification/sgb_tb_asserts.sv
verification/sgb_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module sgb_tb \
	-f verilog.f -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/Vsgb_tb +verilator+error+limit+100 > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status, see $SIM_LOG"
	exit 1
fi

if grep -q "TEST PASSED" "$SIM_LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $SIM_LOG"
exit 1
